/* event_builder_top.f */
+incdir+.
event_builder_pkg.sv
buffer_port_if.sv
link_writer.sv
buffer_arbiter.sv
event_buffer_ram.sv
completion_tracker.sv
event_readout.sv
event_builder_top.sv
tb_event_builder.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_event_builder -f event_builder_top.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_event_builder 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* tb_event_builder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

module tb_event_builder;
    localparam int          CLK_HALF        = 4;
    localparam logic [31:0] LCG_SEED        = 32'heb90_c1c8;
    localparam int          MAX_FRAG        = 80;
    // output words summed over all tests
    localparam int          TOTAL_WORDS     = 27 + 13 + 30 + 73;
    localparam int          WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 2000;

    logic                                     aclk;
    logic                                     arst_n_i;
    logic                                     event_open_i;
    logic [`EB_NUM_LINKS-1:0]                 link_mask_i;
    logic [`EB_NUM_LINKS-1:0][`EB_DATA_W-1:0] s_link_tdata_i;
    logic [`EB_NUM_LINKS-1:0]                 s_link_tvalid_i;
    logic [`EB_NUM_LINKS-1:0]                 s_link_tlast_i;
    logic [`EB_NUM_LINKS-1:0]                 s_link_tready_o;
    logic [`EB_DATA_W-1:0]                    m_ev_tdata_o;
    logic                                     m_ev_tvalid_o;
    logic                                     m_ev_tlast_o;
    logic                                     m_ev_tready_i;
    logic                                     evin_complete_o;
    logic [`EB_NUM_LINKS-1:0]                 overflow_err_o;

    // fragments for the next event, one row per link
    logic [`EB_DATA_W-1:0] frag_words [`EB_NUM_LINKS][MAX_FRAG];
    int                    frag_len   [`EB_NUM_LINKS];

    logic [`EB_DATA_W-1:0] exp_data [$];
    logic                  exp_last [$];
    logic [`EB_DATA_W-1:0] got_data [$];
    logic                  got_last [$];

    int                    complete_count = 0;
    logic [31:0]           gen_state      = LCG_SEED;
    logic [31:0]           stall_state    = LCG_SEED;
    logic                  stall_en;
    logic                  prev_stalled   = 1'b0;
    logic [`EB_DATA_W-1:0] prev_data      = '0;
    logic                  prev_last      = 1'b0;

    event_builder_top u_dut (
        .aclk            (aclk),
        .arst_n_i        (arst_n_i),
        .event_open_i    (event_open_i),
        .link_mask_i     (link_mask_i),
        .s_link_tdata_i  (s_link_tdata_i),
        .s_link_tvalid_i (s_link_tvalid_i),
        .s_link_tlast_i  (s_link_tlast_i),
        .s_link_tready_o (s_link_tready_o),
        .m_ev_tdata_o    (m_ev_tdata_o),
        .m_ev_tvalid_o   (m_ev_tvalid_o),
        .m_ev_tlast_o    (m_ev_tlast_o),
        .m_ev_tready_i   (m_ev_tready_i),
        .evin_complete_o (evin_complete_o),
        .overflow_err_o  (overflow_err_o)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%08h expected 0x%08h",
                                        name, got, exp));
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #CLK_HALF aclk = ~aclk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        stop_with_failure("watchdog expired before all tests finished");
    end

    // sink readiness, random only while stalling is enabled
    initial begin
        m_ev_tready_i = 1'b1;
        forever begin
            @(posedge aclk);
            if (stall_en) begin
                stall_state = lcg_step(stall_state);
                m_ev_tready_i <= stall_state[16];
            end else begin
                m_ev_tready_i <= 1'b1;
            end
        end
    end

    // output collector and stream rule checks, sampled mid-cycle
    always @(negedge aclk) begin
        if (arst_n_i) begin
            if (evin_complete_o) complete_count++;
            if (prev_stalled) begin
                check_value("m_ev_tvalid_o", 32'(m_ev_tvalid_o), 32'd1);
                check_value("m_ev_tdata_o", m_ev_tdata_o, prev_data);
                check_value("m_ev_tlast_o", 32'(m_ev_tlast_o), 32'(prev_last));
            end
            if (m_ev_tvalid_o && m_ev_tready_i) begin
                got_data.push_back(m_ev_tdata_o);
                got_last.push_back(m_ev_tlast_o);
            end
            prev_stalled = m_ev_tvalid_o && !m_ev_tready_i;
            prev_data    = m_ev_tdata_o;
            prev_last    = m_ev_tlast_o;
            // closed window or masked link swallows everything
            for (int i = 0; i < `EB_NUM_LINKS; i++) begin
                if (!event_open_i || link_mask_i[i]) begin
                    check_value("s_link_tready_o", 32'(s_link_tready_o[i]), 32'd1);
                end
            end
        end
    end

    task automatic make_fragments(input int len0, input int len1, input int len2,
                                  input int len3);
        frag_len[0] = len0;
        frag_len[1] = len1;
        frag_len[2] = len2;
        frag_len[3] = len3;
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            for (int k = 0; k < frag_len[l]; k++) begin
                gen_state         = lcg_step(gen_state);
                frag_words[l][k] = gen_state;
            end
        end
    endtask

    // unmasked links in ascending order, each capped at the region depth
    task automatic expect_event(input logic [`EB_NUM_LINKS-1:0] mask);
        int first;
        int n;
        first = exp_data.size();
        for (int l = 0; l < `EB_NUM_LINKS; l++) begin
            if (!mask[l]) begin
                n = (frag_len[l] > `EB_REGION_WORDS) ? `EB_REGION_WORDS : frag_len[l];
                for (int k = 0; k < n; k++) begin
                    exp_data.push_back(frag_words[l][k]);
                    exp_last.push_back(1'b0);
                end
            end
        end
        if (exp_data.size() > first) exp_last[exp_last.size()-1] = 1'b1;
    endtask

    task automatic send_link(input int link);
        int k;
        k = 0;
        while (k < frag_len[link]) begin
            @(posedge aclk);
            s_link_tdata_i[link]  <= frag_words[link][k];
            s_link_tvalid_i[link] <= 1'b1;
            s_link_tlast_i[link]  <= (k == frag_len[link] - 1);
            @(negedge aclk);
            while (!s_link_tready_o[link]) @(negedge aclk);
            k++;
        end
        @(posedge aclk);
        s_link_tvalid_i[link] <= 1'b0;
        s_link_tlast_i[link]  <= 1'b0;
    endtask

    task automatic send_all_links();
        fork
            send_link(0);
            send_link(1);
            send_link(2);
            send_link(3);
        join
    endtask

    task automatic wait_output(input int n);
        int cycles;
        cycles = 0;
        while (got_data.size() < n) begin
            @(negedge aclk);
            cycles++;
            if (cycles > 200 * n + 200) begin
                stop_with_failure("timed out waiting for event words on the output stream");
            end
        end
    endtask

    task automatic wait_complete(input int n);
        int cycles;
        cycles = 0;
        while (complete_count < n) begin
            @(negedge aclk);
            cycles++;
            if (cycles > 2000) stop_with_failure("no event complete pulse appeared");
        end
    endtask

    task automatic wait_links_ready();
        int cycles;
        cycles = 0;
        while (s_link_tready_o !== '1) begin
            @(negedge aclk);
            cycles++;
            if (cycles > 2000) stop_with_failure("link writers were not released after readout");
        end
    endtask

    task automatic finish_event(input int pulses, input logic [`EB_NUM_LINKS-1:0] exp_ovf);
        wait_output(exp_data.size());
        wait_links_ready();
        // room for stray words after the last one
        repeat (20) @(negedge aclk);
        check_value("output word count", 32'(got_data.size()), 32'(exp_data.size()));
        for (int k = 0; k < exp_data.size(); k++) begin
            check_value("m_ev_tdata_o", got_data[k], exp_data[k]);
            check_value("m_ev_tlast_o", 32'(got_last[k]), 32'(exp_last[k]));
        end
        check_value("evin_complete_o pulses", 32'(complete_count), 32'(pulses));
        check_value("overflow_err_o", 32'(overflow_err_o), 32'(exp_ovf));
        got_data.delete();
        got_last.delete();
        exp_data.delete();
        exp_last.delete();
    endtask

    task automatic test_all_links();
        complete_count = 0;
        make_fragments(5, 12, 1, 9);
        expect_event(4'b0000);
        send_all_links();
        finish_event(1, 4'b0000);
    endtask

    task automatic test_masked_links();
        @(posedge aclk);
        link_mask_i <= 4'b1010;
        complete_count = 0;
        make_fragments(6, 4, 7, 3);
        expect_event(4'b1010);
        send_all_links();
        finish_event(1, 4'b0000);
    endtask

    task automatic test_closed_window();
        @(posedge aclk);
        event_open_i <= 1'b0;
        link_mask_i  <= 4'b0000;
        complete_count = 0;
        make_fragments(4, 4, 4, 4);
        send_all_links();
        repeat (100) @(negedge aclk);
        check_value("output word count", 32'(got_data.size()), 32'd0);
        check_value("evin_complete_o pulses", 32'(complete_count), 32'd0);
        @(posedge aclk);
        event_open_i <= 1'b1;
    endtask

    task automatic test_readout_stall();
        @(posedge aclk);
        stall_en <= 1'b1;
        complete_count = 0;
        make_fragments(3, 5, 2, 6);
        expect_event(4'b0000);
        send_all_links();
        // second event is offered while the first one drains
        wait_complete(1);
        make_fragments(4, 1, 7, 2);
        expect_event(4'b0000);
        send_all_links();
        finish_event(2, 4'b0000);
        @(posedge aclk);
        stall_en <= 1'b0;
    endtask

    task automatic test_overflow();
        complete_count = 0;
        make_fragments(3, 2, 70, 4);
        expect_event(4'b0000);
        send_all_links();
        finish_event(1, 4'b0100);
    endtask

    initial begin
        arst_n_i        = 1'b0;
        event_open_i    = 1'b0;
        link_mask_i     = '0;
        s_link_tdata_i  = '0;
        s_link_tvalid_i = '0;
        s_link_tlast_i  = '0;
        stall_en        = 1'b0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        check_value("m_ev_tvalid_o", 32'(m_ev_tvalid_o), 32'd0);
        check_value("evin_complete_o", 32'(evin_complete_o), 32'd0);
        check_value("overflow_err_o", 32'(overflow_err_o), 32'd0);
        check_value("s_link_tready_o", 32'(s_link_tready_o), 32'hf);
        @(posedge aclk);
        arst_n_i     <= 1'b1;
        event_open_i <= 1'b1;

        test_all_links();
        test_masked_links();
        test_closed_window();
        test_readout_stall();
        test_overflow();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* event_builder_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

module event_builder_top
    import event_builder_pkg::*;
(
    input  logic                                      aclk,
    input  logic                                      arst_n_i,
    input  logic                                      event_open_i,
    input  logic [`EB_NUM_LINKS-1:0]                  link_mask_i,
    input  logic [`EB_NUM_LINKS-1:0][`EB_DATA_W-1:0]  s_link_tdata_i,
    input  logic [`EB_NUM_LINKS-1:0]                  s_link_tvalid_i,
    input  logic [`EB_NUM_LINKS-1:0]                  s_link_tlast_i,
    output logic [`EB_NUM_LINKS-1:0]                  s_link_tready_o,
    output logic [`EB_DATA_W-1:0]                     m_ev_tdata_o,
    output logic                                      m_ev_tvalid_o,
    output logic                                      m_ev_tlast_o,
    input  logic                                      m_ev_tready_i,
    output logic                                      evin_complete_o,
    output logic [`EB_NUM_LINKS-1:0]                  overflow_err_o
);
    logic [`EB_NUM_LINKS-1:0] link_active;
    logic [`EB_NUM_LINKS-1:0] link_done;
    logic [`EB_OFS_W:0]       word_count [`EB_NUM_LINKS];
    logic                     ev_release;
    logic                     ram_we;
    buf_addr_u                ram_addr;
    logic [`EB_DATA_W-1:0]    ram_wdata;
    logic [`EB_DATA_W-1:0]    ram_rdata;

    // ports 0..3 are the link writers, the last one is the readout
    buffer_port_if buf_ports [`EB_NUM_REQ] ();

    for (genvar i = 0; i < `EB_NUM_LINKS; i++) begin : g_link
        assign link_active[i] = event_open_i && !link_mask_i[i];

        link_writer u_writer (
            .aclk         (aclk),
            .arst_n_i     (arst_n_i),
            .link_id_i    (link_idx_t'(i)),
            .active_i     (link_active[i]),
            .s_tdata_i    (s_link_tdata_i[i]),
            .s_tvalid_i   (s_link_tvalid_i[i]),
            .s_tlast_i    (s_link_tlast_i[i]),
            .s_tready_o   (s_link_tready_o[i]),
            .buf_port     (buf_ports[i]),
            .release_i    (ev_release),
            .done_o       (link_done[i]),
            .word_count_o (word_count[i]),
            .overflow_o   (overflow_err_o[i])
        );
    end

    buffer_arbiter u_arbiter (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .req_ports   (buf_ports),
        .ram_we_o    (ram_we),
        .ram_addr_o  (ram_addr),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    event_buffer_ram u_ram (
        .aclk    (aclk),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    completion_tracker u_tracker (
        .aclk             (aclk),
        .arst_n_i         (arst_n_i),
        .link_mask_i      (link_mask_i),
        .done_i           (link_done),
        .release_i        (ev_release),
        .event_complete_o (evin_complete_o)
    );

    event_readout u_readout (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .start_i      (evin_complete_o),
        .link_mask_i  (link_mask_i),
        .word_count_i (word_count),
        .buf_port     (buf_ports[`EB_NUM_REQ-1]),
        .m_tdata_o    (m_ev_tdata_o),
        .m_tvalid_o   (m_ev_tvalid_o),
        .m_tlast_o    (m_ev_tlast_o),
        .m_tready_i   (m_ev_tready_i),
        .release_o    (ev_release)
    );

endmodule

`default_nettype wire

/* event_readout.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

module event_readout
    import event_builder_pkg::*;
(
    input  logic                    aclk,
    input  logic                    arst_n_i,
    input  logic                    start_i,
    input  logic [`EB_NUM_LINKS-1:0] link_mask_i,
    input  logic [`EB_OFS_W:0]      word_count_i [`EB_NUM_LINKS],
    buffer_port_if.requester        buf_port,
    output logic [`EB_DATA_W-1:0]   m_tdata_o,
    output logic                    m_tvalid_o,
    output logic                    m_tlast_o,
    input  logic                    m_tready_i,
    output logic                    release_o
);
    logic                  busy_q;
    link_idx_t             link_q;
    logic [`EB_OFS_W:0]    ofs_q;
    logic                  req_q;
    buf_addr_u             addr_q;
    logic                  inflight_q;
    logic                  inflight_last_q;
    logic                  out_valid_q;
    logic                  out_last_q;
    logic [`EB_DATA_W-1:0] out_data_q;
    logic                  release_q;
    link_idx_t             last_link;
    logic                  link_has_word;
    logic                  final_word;
    logic                  can_issue;

    // highest unmasked link that holds data carries tlast
    always_comb begin
        last_link = '0;
        for (int i = 0; i < `EB_NUM_LINKS; i++) begin
            if (!link_mask_i[i] && word_count_i[i] != '0) last_link = link_idx_t'(i);
        end
    end

    assign link_has_word = !link_mask_i[link_q] && (ofs_q < word_count_i[link_q]);
    assign final_word    = (link_q == last_link) && ((ofs_q + 1'b1) == word_count_i[link_q]);
    // one word in flight at a time, and only into an empty output register
    assign can_issue     = busy_q && !req_q && !inflight_q && !out_valid_q;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q          <= 1'b0;
            link_q          <= '0;
            ofs_q           <= '0;
            req_q           <= 1'b0;
            inflight_q      <= 1'b0;
            inflight_last_q <= 1'b0;
            out_valid_q     <= 1'b0;
            out_last_q      <= 1'b0;
            release_q       <= 1'b0;
        end else begin
            release_q <= 1'b0;
            if (start_i && !busy_q) begin
                busy_q <= 1'b1;
                link_q <= '0;
                ofs_q  <= '0;
            end else if (can_issue) begin
                if (link_has_word) begin
                    req_q           <= 1'b1;
                    inflight_last_q <= final_word;
                    ofs_q           <= ofs_q + 1'b1;
                    if (final_word) busy_q <= 1'b0;
                end else if (link_q == link_idx_t'(`EB_NUM_LINKS - 1)) begin
                    // ran past the last region without data
                    busy_q    <= 1'b0;
                    release_q <= 1'b1;
                end else begin
                    link_q <= link_q + 1'b1;
                    ofs_q  <= '0;
                end
            end
            if (req_q && buf_port.gnt) begin
                req_q      <= 1'b0;
                inflight_q <= 1'b1;
            end
            if (inflight_q && buf_port.rvalid) begin
                inflight_q  <= 1'b0;
                out_valid_q <= 1'b1;
                out_last_q  <= inflight_last_q;
            end
            if (out_valid_q && m_tready_i) begin
                out_valid_q <= 1'b0;
                if (out_last_q) release_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (can_issue && link_has_word) begin
            addr_q.fields.link <= link_q;
            addr_q.fields.ofs  <= ofs_q[`EB_OFS_W-1:0];
        end
        if (inflight_q && buf_port.rvalid) out_data_q <= buf_port.rdata;
    end

    assign buf_port.req   = req_q;
    assign buf_port.we    = 1'b0;
    assign buf_port.addr  = addr_q;
    assign buf_port.wdata = '0;

    assign m_tdata_o  = out_data_q;
    assign m_tvalid_o = out_valid_q;
    assign m_tlast_o  = out_last_q;
    assign release_o  = release_q;

endmodule

`default_nettype wire

/* completion_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

module completion_tracker (
    input  logic                    aclk,
    input  logic                    arst_n_i,
    input  logic [`EB_NUM_LINKS-1:0] link_mask_i,
    input  logic [`EB_NUM_LINKS-1:0] done_i,
    input  logic                    release_i,
    output logic                    event_complete_o
);
    logic all_done;
    logic any_active;
    logic fired_q;
    logic complete_q;

    // masked links count as finished
    assign all_done   = &(done_i | link_mask_i);
    // nothing to build when every link is masked
    assign any_active = !(&link_mask_i);

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fired_q    <= 1'b0;
            complete_q <= 1'b0;
        end else begin
            complete_q <= 1'b0;
            if (release_i) begin
                fired_q <= 1'b0;
            end else if (all_done && any_active && !fired_q) begin
                // one pulse per event, rearmed by the readout
                fired_q    <= 1'b1;
                complete_q <= 1'b1;
            end
        end
    end

    assign event_complete_o = complete_q;

endmodule

`default_nettype wire

/* event_buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

module event_buffer_ram
    import event_builder_pkg::*;
(
    input  logic                  aclk,
    input  logic                  we_i,
    input  buf_addr_u             addr_i,
    input  logic [`EB_DATA_W-1:0] wdata_i,
    output logic [`EB_DATA_W-1:0] rdata_o
);
    // one region of EB_REGION_WORDS per link, back to back
    logic [`EB_DATA_W-1:0] mem [`EB_NUM_LINKS * `EB_REGION_WORDS];

    always_ff @(posedge aclk) begin
        if (we_i) begin
            mem[addr_i.flat] <= wdata_i;
        end
        // read-first, data shows up one cycle later
        rdata_o <= mem[addr_i.flat];
    end

endmodule

`default_nettype wire

/* buffer_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

module buffer_arbiter
    import event_builder_pkg::*;
(
    input  logic                  aclk,
    input  logic                  arst_n_i,
    buffer_port_if.arbiter        req_ports [`EB_NUM_REQ],
    output logic                  ram_we_o,
    output buf_addr_u             ram_addr_o,
    output logic [`EB_DATA_W-1:0] ram_wdata_o,
    input  logic [`EB_DATA_W-1:0] ram_rdata_i
);
    localparam int REQ_W = $clog2(`EB_NUM_REQ);

    logic [`EB_NUM_REQ-1:0] req_vec;
    logic [`EB_NUM_REQ-1:0] we_vec;
    buf_addr_u              addr_vec  [`EB_NUM_REQ];
    logic [`EB_DATA_W-1:0]  wdata_vec [`EB_NUM_REQ];
    logic [`EB_NUM_REQ-1:0] gnt_vec;
    logic                   found;
    logic [REQ_W-1:0]       win;
    logic [REQ_W-1:0]       last_q;
    logic                   rd_pend_q;
    logic [REQ_W-1:0]       rd_id_q;

    // search starts one past the previous winner
    always_comb begin
        int unsigned idx;
        found = 1'b0;
        win   = last_q;
        for (int k = 1; k <= `EB_NUM_REQ; k++) begin
            idx = (int'(last_q) + k) % `EB_NUM_REQ;
            if (!found && req_vec[idx]) begin
                found = 1'b1;
                win   = REQ_W'(idx);
            end
        end
        gnt_vec = '0;
        if (found) gnt_vec[win] = 1'b1;
    end

    assign ram_we_o    = found && we_vec[win];
    assign ram_addr_o  = addr_vec[win];
    assign ram_wdata_o = wdata_vec[win];

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // requester 0 has first pick after reset
            last_q    <= REQ_W'(`EB_NUM_REQ - 1);
            rd_pend_q <= 1'b0;
        end else begin
            if (found) last_q <= win;
            rd_pend_q <= found && !we_vec[win];
        end
    end

    always_ff @(posedge aclk) begin
        rd_id_q <= win;
    end

    for (genvar i = 0; i < `EB_NUM_REQ; i++) begin : g_port
        assign req_vec[i]          = req_ports[i].req;
        assign we_vec[i]           = req_ports[i].we;
        assign addr_vec[i]         = req_ports[i].addr;
        assign wdata_vec[i]        = req_ports[i].wdata;
        assign req_ports[i].gnt    = gnt_vec[i];
        assign req_ports[i].rdata  = ram_rdata_i;
        assign req_ports[i].rvalid = rd_pend_q && (rd_id_q == REQ_W'(i));
    end

endmodule

`default_nettype wire

/* link_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

module link_writer
    import event_builder_pkg::*;
(
    input  logic                  aclk,
    input  logic                  arst_n_i,
    input  link_idx_t             link_id_i,
    input  logic                  active_i,
    input  logic [`EB_DATA_W-1:0] s_tdata_i,
    input  logic                  s_tvalid_i,
    input  logic                  s_tlast_i,
    output logic                  s_tready_o,
    buffer_port_if.requester      buf_port,
    input  logic                  release_i,
    output logic                  done_o,
    output logic [`EB_OFS_W:0]    word_count_o,
    output logic                  overflow_o
);
    logic                  pend_q;
    logic                  pend_last_q;
    logic [`EB_DATA_W-1:0] data_q;
    logic [`EB_OFS_W:0]    count_q;
    logic                  done_q;
    logic                  overflow_q;
    logic                  region_full;
    logic                  accept;
    buf_addr_u             wr_addr;

    // inactive links swallow everything
    assign s_tready_o  = !active_i || (!pend_q && !done_q);
    assign accept      = active_i && s_tvalid_i && !pend_q && !done_q;
    assign region_full = (count_q >= `EB_REGION_WORDS);

    // region of this link, next free word
    always_comb begin
        wr_addr.fields.link = link_id_i;
        wr_addr.fields.ofs  = count_q[`EB_OFS_W-1:0];
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q      <= 1'b0;
            pend_last_q <= 1'b0;
            count_q     <= '0;
            done_q      <= 1'b0;
            overflow_q  <= 1'b0;
        end else begin
            if (pend_q && buf_port.gnt) begin
                pend_q  <= 1'b0;
                count_q <= count_q + 1'b1;
                done_q  <= pend_last_q;
            end else if (accept) begin
                if (region_full) begin
                    // no room left, word is dropped but the fragment can still end here
                    overflow_q <= 1'b1;
                    done_q     <= s_tlast_i;
                end else begin
                    pend_q      <= 1'b1;
                    pend_last_q <= s_tlast_i;
                end
            end
            if (release_i) begin
                done_q  <= 1'b0;
                count_q <= '0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && !region_full) data_q <= s_tdata_i;
    end

    assign buf_port.req   = pend_q;
    assign buf_port.we    = 1'b1;
    assign buf_port.addr  = wr_addr;
    assign buf_port.wdata = data_q;

    assign done_o       = done_q;
    assign word_count_o = count_q;
    assign overflow_o   = overflow_q;

endmodule

`default_nettype wire

/* buffer_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "event_builder_defines.svh"

// one requester port on the shared event buffer
interface buffer_port_if
    import event_builder_pkg::*;
();
    logic                  req;
    logic                  we;
    buf_addr_u             addr;
    logic [`EB_DATA_W-1:0] wdata;
    logic                  gnt;
    logic [`EB_DATA_W-1:0] rdata;
    logic                  rvalid;

    // held stable by the requester until gnt
    modport requester (output req, we, addr, wdata, input gnt, rdata, rvalid);

    modport arbiter (input req, we, addr, wdata, output gnt, rdata, rvalid);

endinterface

`default_nettype wire

/* event_builder_pkg.sv */
`default_nettype none

`include "event_builder_defines.svh"

package event_builder_pkg;

    // number of one detector link
    typedef logic [`EB_LINK_W-1:0] link_idx_t;

    // one buffer address
    // arbiter and RAM see a flat word index, the link side sees region and offset
    typedef union packed {
        logic [`EB_ADDR_W-1:0] flat;
        struct packed {
            link_idx_t             link;
            logic [`EB_OFS_W-1:0]  ofs;
        } fields;
    } buf_addr_u;

endpackage

`default_nettype wire

/* event_builder_defines.svh */
`ifndef EVENT_BUILDER_DEFINES_SVH
`define EVENT_BUILDER_DEFINES_SVH

// detector links feeding the builder
`define EB_NUM_LINKS 4

// width of one link word and of one buffer word
`define EB_DATA_W 32

// word offset inside one link region
`define EB_OFS_W 6
`define EB_REGION_WORDS 64

// link index, upper part of a buffer address
`define EB_LINK_W 2
`define EB_ADDR_W (`EB_LINK_W + `EB_OFS_W)

// four link writers plus the readout engine
`define EB_NUM_REQ 5

`endif
